/* src/denoise_pkg.sv */
// Denoiser shared definitions
// Pixel, luma and block statistics payloads plus the Wiener gain format
`default_nettype none

package denoise_pkg;

	typedef struct packed {
		logic [7:0] pad;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;    // Low byte of the input word
	} rgb_pixel_t;

	typedef logic [7:0]  luma_t;
	typedef logic [15:0] block_var_t;

	// Payload from the block buffer to the Wiener stage
	typedef struct packed {
		luma_t      luma;
		luma_t      block_mean;
		block_var_t block_var;
	} stats_pixel_t;

	localparam int GAIN_FRAC_BITS = 8;    // Gain of 256 is unity

endpackage

`default_nettype wire

/* src/pixel_stream_if.sv */
// Pixel stream interface
// Valid/ready handshake with a typed payload and frame/block markers
`timescale 1ns/1ps
`default_nettype none

interface pixel_stream_if #(
	parameter type payload_t = logic [7:0]
);
	logic     valid;
	logic     ready;
	payload_t data;
	logic     sof;     // First pixel of a frame
	logic     last;    // Last pixel of a block

	modport src (output valid, output data, output sof, output last, input ready);
	modport dst (input valid, input data, input sof, input last, output ready);
	modport mon (input valid, input ready, input data, input sof, input last);

endinterface

`default_nettype wire

/* src/rgb_to_luma.sv */
// RGB to luma stage
// Registers the floor mean of the three colour channels of each pixel
`timescale 1ns/1ps
`default_nettype none

module rgb_to_luma
	import denoise_pkg::*;
(
	input wire logic    clk,
	input wire logic    rst_n,
	pixel_stream_if.dst in,
	pixel_stream_if.src out
);
	rgb_pixel_t  px;
	logic [9:0]  chan_sum;
	logic [18:0] scaled;
	luma_t       luma_q;
	logic        valid_q;
	logic        sof_q;
	logic        last_q;

	assign px       = in.data;
	assign chan_sum = px.r + px.g + px.b;
	assign scaled   = chan_sum * 19'd683;    // 683 / 2048 is exact floor of /3 up to 765

	// Take a new pixel when the register is empty or draining
	assign in.ready = !valid_q || out.ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in.valid && in.ready) begin
			valid_q <= 1'b1;
		end else if (out.ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid && in.ready) begin
			luma_q <= scaled[18:11];
			sof_q  <= in.sof;
			last_q <= in.last;
		end
	end

	assign out.valid = valid_q;
	assign out.data  = luma_q;
	assign out.sof   = sof_q;
	assign out.last  = last_q;

endmodule

`default_nettype wire

/* src/block_stats_buffer.sv */
// Block statistics buffer
// Collects one block of luma, forms its mean and variance, then replays
// the block with both values attached to every pixel
`timescale 1ns/1ps
`default_nettype none

module block_stats_buffer
	import denoise_pkg::*;
#(
	parameter int BLOCK_PIXELS = 64
) (
	input wire logic    clk,
	input wire logic    rst_n,
	pixel_stream_if.dst in,
	pixel_stream_if.src out
);
	localparam int IDX_W = $clog2(BLOCK_PIXELS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BLOCK_PIXELS - 1);

	typedef enum logic [1:0] {COLLECT, COMPUTE, REPLAY} state_t;

	state_t            state;
	luma_t             block_mem [BLOCK_PIXELS];
	logic [IDX_W-1:0]  wr_idx;
	logic [IDX_W-1:0]  rd_idx;
	logic [IDX_W+7:0]  sum;
	logic [IDX_W+15:0] sum_sq;
	logic [15:0]       in_sq;
	logic              blk_sof;
	luma_t             mean_c;
	logic [15:0]       sq_mean;
	logic [15:0]       mean_sq;
	luma_t             mean_q;
	block_var_t        var_q;
	stats_pixel_t      out_pix;
	logic              in_fire;
	logic              out_fire;

	assign in.ready = (state == COLLECT);
	assign in_fire  = in.valid && in.ready;
	assign out_fire = out.valid && out.ready;

	assign in_sq   = in.data * in.data;
	assign mean_c  = sum[IDX_W +: 8];       // Divide by the block size
	assign sq_mean = sum_sq[IDX_W +: 16];
	assign mean_sq = mean_c * mean_c;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= COLLECT;
			wr_idx  <= '0;
			rd_idx  <= '0;
			blk_sof <= 1'b0;
		end else begin
			case (state)
				COLLECT: begin
					if (in_fire) begin
						if (wr_idx == '0) begin
							blk_sof <= in.sof;
						end
						wr_idx <= wr_idx + 1'b1;    // Wraps to 0 at block end
						if (wr_idx == LAST_IDX) begin
							state <= COMPUTE;
						end
					end
				end
				COMPUTE: state <= REPLAY;
				REPLAY: begin
					if (out_fire) begin
						rd_idx <= rd_idx + 1'b1;
						if (rd_idx == LAST_IDX) begin
							state <= COLLECT;
						end
					end
				end
				default: state <= COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			block_mem[wr_idx] <= in.data;
			if (wr_idx == '0) begin
				sum    <= (IDX_W+8)'(in.data);
				sum_sq <= (IDX_W+16)'(in_sq);
			end else begin
				sum    <= sum + in.data;
				sum_sq <= sum_sq + in_sq;
			end
		end
		if (state == COMPUTE) begin
			mean_q <= mean_c;
			var_q  <= (sq_mean > mean_sq) ? sq_mean - mean_sq : '0;
		end
	end

	assign out_pix.luma       = block_mem[rd_idx];
	assign out_pix.block_mean = mean_q;
	assign out_pix.block_var  = var_q;

	assign out.valid = (state == REPLAY);
	assign out.data  = out_pix;
	assign out.sof   = blk_sof && (rd_idx == '0);
	assign out.last  = (rd_idx == LAST_IDX);

endmodule

`default_nettype wire

/* src/noise_estimator.sv */
// Noise estimator
// Tracks the minimum block variance of each frame and publishes it
// once the frame's final block has gone by
`timescale 1ns/1ps
`default_nettype none

module noise_estimator
	import denoise_pkg::*;
(
	input wire logic        clk,
	input wire logic        rst_n,
	pixel_stream_if.mon     stats,
	input wire logic [31:0] blocks_per_frame,
	output block_var_t      noise_variance,
	output logic            noise_valid
);
	stats_pixel_t pix;
	logic         sof_fire;
	logic         blk_done;
	logic [31:0]  blk_cnt;
	logic [31:0]  cnt_next;
	block_var_t   min_var;
	block_var_t   min_base;
	block_var_t   min_next;

	assign pix      = stats.data;
	assign sof_fire = stats.valid && stats.ready && stats.sof;
	assign blk_done = stats.valid && stats.ready && stats.last;

	// A frame start on the same transfer restarts the count
	assign cnt_next = (sof_fire ? 32'd0 : blk_cnt) + 32'd1;
	assign min_base = sof_fire ? '1 : min_var;
	assign min_next = (pix.block_var < min_base) ? pix.block_var : min_base;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			blk_cnt        <= '0;
			min_var        <= '1;
			noise_variance <= '0;
			noise_valid    <= 1'b0;
		end else begin
			noise_valid <= 1'b0;
			if (blk_done) begin
				if (cnt_next == blocks_per_frame) begin
					noise_variance <= min_next;    // Frame complete
					noise_valid    <= 1'b1;
					blk_cnt        <= '0;
					min_var        <= '1;
				end else begin
					blk_cnt <= cnt_next;
					min_var <= min_next;
				end
			end else if (sof_fire) begin
				blk_cnt <= '0;
				min_var <= '1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/wiener_filter.sv */
// Wiener filter stage
// Derives a gain per block with a serial divider, then pulls each pixel
// toward its block mean by that gain
`timescale 1ns/1ps
`default_nettype none

module wiener_filter
	import denoise_pkg::*;
(
	input wire logic       clk,
	input wire logic       rst_n,
	pixel_stream_if.dst    in,
	input wire block_var_t noise_variance,
	pixel_stream_if.src    out
);
	localparam logic [GAIN_FRAC_BITS:0] UNITY = {1'b1, {GAIN_FRAC_BITS{1'b0}}};
	localparam logic [3:0] DIV_LAST = 4'(GAIN_FRAC_BITS - 1);

	typedef enum logic [1:0] {IDLE, DIV, PASS} state_t;

	state_t                    state;
	stats_pixel_t              pix;
	block_var_t                noise_q;
	block_var_t                noise_eff;
	block_var_t                divisor;
	logic [15:0]               rem;
	logic [16:0]               rem_sh;
	logic [GAIN_FRAC_BITS-1:0] quot;
	logic [3:0]                div_cnt;
	logic                      gain_zero;
	logic                      gain_unity;
	logic [GAIN_FRAC_BITS:0]   gain;
	logic signed [9:0]         diff;
	logic signed [19:0]        prod;
	logic signed [19:0]        shifted;
	logic signed [11:0]        res;
	luma_t                     res_clamped;
	luma_t                     data_q;
	logic                      valid_q;
	logic                      sof_q;
	logic                      last_q;
	logic                      in_fire;

	assign pix       = in.data;
	assign noise_eff = in.sof ? noise_variance : noise_q;    // New frame takes the fresh estimate
	assign rem_sh    = {rem, 1'b0};

	assign in.ready = (state == PASS) && (!valid_q || out.ready);
	assign in_fire  = in.valid && in.ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= IDLE;
			noise_q <= '0;
			div_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (in.valid) begin
						if (in.sof) begin
							noise_q <= noise_variance;
						end
						div_cnt <= '0;
						state   <= DIV;
					end
				end
				DIV: begin
					div_cnt <= div_cnt + 1'b1;
					if (div_cnt == DIV_LAST) begin
						state <= PASS;
					end
				end
				PASS: begin
					if (in_fire && in.last) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Restoring division of (var - noise) * 2^8 by var, one quotient bit per cycle
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			divisor    <= pix.block_var;
			rem        <= pix.block_var - noise_eff;
			gain_zero  <= (pix.block_var <= noise_eff);
			gain_unity <= (noise_eff == '0);
		end else if (state == DIV) begin
			if (rem_sh >= {1'b0, divisor}) begin
				rem  <= 16'(rem_sh - {1'b0, divisor});
				quot <= {quot[GAIN_FRAC_BITS-2:0], 1'b1};
			end else begin
				rem  <= rem_sh[15:0];
				quot <= {quot[GAIN_FRAC_BITS-2:0], 1'b0};
			end
		end
	end

	// No estimate yet means pass luma through
	always_comb begin
		if (gain_unity) begin
			gain = UNITY;
		end else if (gain_zero) begin
			gain = '0;
		end else begin
			gain = {1'b0, quot};
		end
	end

	assign diff    = $signed({2'b00, pix.luma}) - $signed({2'b00, pix.block_mean});
	assign prod    = $signed({1'b0, gain}) * diff;
	assign shifted = prod >>> GAIN_FRAC_BITS;    // Floors toward minus infinity
	assign res     = $signed(shifted[11:0]) + $signed({4'b0000, pix.block_mean});

	always_comb begin
		if (res < 0) begin
			res_clamped = '0;
		end else if (res > 12'sd255) begin
			res_clamped = 8'hff;
		end else begin
			res_clamped = res[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_fire) begin
			valid_q <= 1'b1;
		end else if (out.ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			data_q <= res_clamped;
			sof_q  <= in.sof;
			last_q <= in.last;
		end
	end

	assign out.valid = valid_q;
	assign out.data  = data_q;
	assign out.sof   = sof_q;
	assign out.last  = last_q;

endmodule

`default_nettype wire

/* src/denoise_top.sv */
// Streaming denoiser top level
// Luma conversion, block statistics and Wiener filtering in a pipeline,
// with a frame noise estimator watching the statistics stream
`timescale 1ns/1ps
`default_nettype none

module denoise_top
	import denoise_pkg::*;
#(
	parameter int BLOCK_SIZE = 8    // Power of two
) (
	input wire logic        clk,
	input wire logic        rst_n,
	input wire logic [31:0] s_tdata,
	input wire logic        s_tvalid,
	output logic            s_tready,
	input wire logic        s_tuser,     // Start of frame
	input wire logic        s_tlast,     // End of block
	input wire logic [31:0] blocks_per_frame,
	output luma_t           m_tdata,
	output logic            m_tvalid,
	input wire logic        m_tready,
	output logic            m_tuser,
	output logic            m_tlast,
	output block_var_t      estimated_noise,
	output logic            estimated_noise_valid
);
	localparam int BLOCK_PIXELS = BLOCK_SIZE * BLOCK_SIZE;

	pixel_stream_if #(.payload_t(rgb_pixel_t))   in_s ();
	pixel_stream_if #(.payload_t(luma_t))        luma_s ();
	pixel_stream_if #(.payload_t(stats_pixel_t)) stats_s ();
	pixel_stream_if #(.payload_t(luma_t))        out_s ();

	assign in_s.valid = s_tvalid;
	assign in_s.data  = rgb_pixel_t'(s_tdata);
	assign in_s.sof   = s_tuser;
	assign in_s.last  = s_tlast;
	assign s_tready   = in_s.ready;

	assign m_tdata     = out_s.data;
	assign m_tvalid    = out_s.valid;
	assign m_tuser     = out_s.sof;
	assign m_tlast     = out_s.last;
	assign out_s.ready = m_tready;

	rgb_to_luma i_rgb_to_luma (
		.clk   (clk),
		.rst_n (rst_n),
		.in    (in_s.dst),
		.out   (luma_s.src)
	);

	block_stats_buffer #(
		.BLOCK_PIXELS(BLOCK_PIXELS)
	) i_block_stats_buffer (
		.clk   (clk),
		.rst_n (rst_n),
		.in    (luma_s.dst),
		.out   (stats_s.src)
	);

	noise_estimator i_noise_estimator (
		.clk              (clk),
		.rst_n            (rst_n),
		.stats            (stats_s.mon),
		.blocks_per_frame (blocks_per_frame),
		.noise_variance   (estimated_noise),
		.noise_valid      (estimated_noise_valid)
	);

	wiener_filter i_wiener_filter (
		.clk            (clk),
		.rst_n          (rst_n),
		.in             (stats_s.dst),
		.noise_variance (estimated_noise),
		.out            (out_s.src)
	);

endmodule

`default_nettype wire

/* tests/denoise_tb.sv */
// Denoiser testbench
// Streams two frames from the golden file under random output back-pressure
// and checks the denoised luma, the block framing and the noise reports
`timescale 1ns/1ps
`default_nettype none

module denoise_tb;

	localparam int BLOCK_SIZE   = 4;
	localparam int BLOCK_PIXELS = BLOCK_SIZE * BLOCK_SIZE;
	localparam int FRAME_PIXELS = BLOCK_PIXELS * 2;    // Two blocks per frame
	localparam int TIMEOUT      = 2000;

	logic        clk;
	logic        rst_n;
	logic [31:0] s_tdata;
	logic        s_tvalid;
	logic        s_tready;
	logic        s_tuser;
	logic        s_tlast;
	logic [31:0] blocks_per_frame;
	logic [7:0]  m_tdata;
	logic        m_tvalid;
	logic        m_tready;
	logic        m_tuser;
	logic        m_tlast;
	logic [15:0] estimated_noise;
	logic        estimated_noise_valid;

	logic [31:0] in_words [$];
	logic [7:0]  exp_luma [$];
	logic        exp_sof [$];
	logic [15:0] exp_noise [$];
	logic [15:0] noise_seen [$];
	int          noise_pos [$];    // Output count when each report arrived
	int          out_idx;
	int          frame1_err;
	int          frame2_err;
	int          framing_err;
	int          pass_count;
	int          fail_count;
	int          errors;
	logic        timed_out;
	integer      seed;

	denoise_top #(
		.BLOCK_SIZE(BLOCK_SIZE)
	) i_denoise_top (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.s_tdata               (s_tdata),
		.s_tvalid              (s_tvalid),
		.s_tready              (s_tready),
		.s_tuser               (s_tuser),
		.s_tlast               (s_tlast),
		.blocks_per_frame      (blocks_per_frame),
		.m_tdata               (m_tdata),
		.m_tvalid              (m_tvalid),
		.m_tready              (m_tready),
		.m_tuser               (m_tuser),
		.m_tlast               (m_tlast),
		.estimated_noise       (estimated_noise),
		.estimated_noise_valid (estimated_noise_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Random sink stalls, roughly one cycle in four
	always @(posedge clk) begin
		#1;
		m_tready = ($random(seed) & 3) != 0;
	end

	// Sampled at the falling edge, where every input is settled
	always @(negedge clk) begin
		if (rst_n && estimated_noise_valid) begin
			noise_seen.push_back(estimated_noise);
			noise_pos.push_back(out_idx);
		end
		if (rst_n && m_tvalid && m_tready) begin
			check_output();
		end
	end

	task automatic check_output;
		logic exp_last;
		if (out_idx >= in_words.size()) begin
			$display("%0t: output pixel beyond the end of the stream", $time);
			framing_err++;
		end else begin
			exp_last = (out_idx % BLOCK_PIXELS) == BLOCK_PIXELS - 1;
			if (m_tdata !== exp_luma[out_idx]) begin
				$display("CHECK FAILED t=%0t m_tdata[%0d]: got %02h expected %02h",
					$time, out_idx, m_tdata, exp_luma[out_idx]);
				if (out_idx < FRAME_PIXELS) frame1_err++;
				else frame2_err++;
			end
			if (m_tuser !== exp_sof[out_idx]) begin
				$display("CHECK FAILED t=%0t m_tuser[%0d]: got %b expected %b",
					$time, out_idx, m_tuser, exp_sof[out_idx]);
				framing_err++;
			end
			if (m_tlast !== exp_last) begin
				$display("CHECK FAILED t=%0t m_tlast[%0d]: got %b expected %b",
					$time, out_idx, m_tlast, exp_last);
				framing_err++;
			end
		end
		out_idx++;
	endtask

	task automatic load_golden;
		integer          fd;
		integer          code;
		integer          sof;
		logic [31:0]     word;
		logic [7:0]      luma;
		logic [15:0]     nv;
		logic [8*8-1:0]  kind;
		logic [8*160-1:0] rest;
		fd = $fopen("tests/denoise_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden data file");
			fail_count++;
		end else begin
			code = $fscanf(fd, "%s", kind);
			while (code == 1) begin
				if (kind == "P") begin
					code = $fscanf(fd, "%h %h %d", word, luma, sof);
					in_words.push_back(word);
					exp_luma.push_back(luma);
					exp_sof.push_back(sof[0]);
				end else if (kind == "N") begin
					code = $fscanf(fd, "%h", nv);
					exp_noise.push_back(nv);
				end else begin
					code = $fgets(rest, fd);    // Comment line
				end
				code = $fscanf(fd, "%s", kind);
			end
			$fclose(fd);
		end
	endtask

	task automatic send_pixel(input int idx);
		int waited;
		s_tdata  = in_words[idx];
		s_tvalid = 1'b1;
		s_tuser  = exp_sof[idx];
		s_tlast  = (idx % BLOCK_PIXELS) == BLOCK_PIXELS - 1;
		waited   = 0;
		@(negedge clk);
		while (!s_tready && waited < TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (!s_tready) flag_timeout("the input handshake");
		@(posedge clk);
		#1;
	endtask

	task automatic wait_outputs(input int n);
		int waited;
		waited = 0;
		while (out_idx < n && waited < TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (out_idx < n) flag_timeout("output pixels");
	endtask

	task automatic wait_noise(input int n);
		int waited;
		waited = 0;
		while (noise_seen.size() < n && waited < TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (noise_seen.size() < n) flag_timeout("a noise report");
	endtask

	task automatic check_noise(input int n);
		if (n >= noise_seen.size() || n >= exp_noise.size()) begin
			$display("noise report %0d is missing", n);
			errors++;
		end else if (noise_seen[n] !== exp_noise[n]) begin
			$display("CHECK FAILED t=%0t estimated_noise: got %04h expected %04h",
				$time, noise_seen[n], exp_noise[n]);
			errors++;
		end
	endtask

	// A test that could not finish its waits counts as failed
	task automatic report(input string name, input int errs);
		if (errs == 0 && !timed_out) begin
			pass_count++;
			$display("PASS %s", name);
		end else begin
			fail_count++;
			$display("FAIL %s (%0d errors)", name, errs);
		end
	endtask

	task automatic flag_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timed_out = 1'b1;
	endtask

	task automatic finish_run;
		$display("summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	initial begin
		rst_n            = 1'b0;
		s_tdata          = '0;
		s_tvalid         = 1'b0;
		s_tuser          = 1'b0;
		s_tlast          = 1'b0;
		m_tready         = 1'b0;
		blocks_per_frame = 32'd2;
		seed             = 32'hfd82e97b;
		out_idx          = 0;
		frame1_err       = 0;
		frame2_err       = 0;
		framing_err      = 0;
		pass_count       = 0;
		fail_count       = 0;
		timed_out        = 1'b0;
		load_golden();

		// Reset for five cycles, state checked in the last one
		errors = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (m_tvalid !== 1'b0) begin
			$display("CHECK FAILED t=%0t m_tvalid: got %b expected 0", $time, m_tvalid);
			errors++;
		end
		if (estimated_noise_valid !== 1'b0) begin
			$display("CHECK FAILED t=%0t estimated_noise_valid: got %b expected 0",
				$time, estimated_noise_valid);
			errors++;
		end
		if (estimated_noise !== 16'h0000) begin
			$display("CHECK FAILED t=%0t estimated_noise: got %04h expected 0000",
				$time, estimated_noise);
			errors++;
		end
		if (s_tready !== 1'b1) begin
			$display("CHECK FAILED t=%0t s_tready: got %b expected 1", $time, s_tready);
			errors++;
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		report("reset state", errors);

		for (int i = 0; i < in_words.size() && !timed_out; i++) begin
			send_pixel(i);
		end
		s_tvalid = 1'b0;
		s_tlast  = 1'b0;

		wait_outputs(FRAME_PIXELS);
		report("frame 1 unity pass-through", frame1_err);

		errors = 0;
		wait_noise(1);
		check_noise(0);
		if (noise_pos.size() > 0 && noise_pos[0] > FRAME_PIXELS) begin
			$display("first noise report arrived after frame 2 output began");
			errors++;
		end
		report("noise report after frame 1", errors);

		wait_outputs(in_words.size());
		report("frame 2 Wiener filtering", frame2_err);

		// Quiet period so that extra outputs or reports can show up
		wait_noise(exp_noise.size());
		repeat (20) @(negedge clk);
		if (out_idx != in_words.size()) begin
			$display("got %0d output pixels instead of %0d", out_idx, in_words.size());
			framing_err++;
		end
		report("back-pressure and framing", framing_err);

		errors = 0;
		if (noise_seen.size() != exp_noise.size()) begin
			$display("saw %0d noise reports instead of %0d", noise_seen.size(),
				exp_noise.size());
			errors++;
		end else begin
			check_noise(1);
			if (noise_pos[1] <= FRAME_PIXELS) begin
				$display("second noise report arrived before frame 2 output");
				errors++;
			end
		end
		report("noise report after frame 2", errors);

		finish_run();
	end

endmodule

`default_nettype wire

/* tests/denoise_golden.txt */
# P <input word: pad r g b, hex> <expected output luma, hex> <start of frame flag>
# N <expected noise variance published after a frame, hex>
P A560555B 5A 1
P 00706A72 6E 0
P 0050645A 5A 0
P A56E6E6E 6E 0
P 00706A72 6E 0
P A560555B 5A 0
P A56E6E6E 6E 0
P 0050645A 5A 0
P A560555B 5A 0
P A56E6E6E 6E 0
P 0050645A 5A 0
P 00706A72 6E 0
P A56E6E6E 6E 0
P 0050645A 5A 0
P 00706A72 6E 0
P A560555B 5A 0
P 0050383A 40 0
P 0080686A 70 0
P A5909092 90 0
P 00FFA0A3 C0 0
P A5C0C0C1 C0 0
P 00A08090 90 0
P 00707071 70 0
P A5404041 40 0
P 0080686A 70 0
P A5404041 40 0
P 00FFA0A3 C0 0
P A5909092 90 0
P 00A08090 90 0
P A5C0C0C1 C0 0
P 0050383A 40 0
P 00707071 70 0
N 0064
P A560555B 64 1
P 00706A72 64 0
P 0050645A 64 0
P A56E6E6E 64 0
P 00706A72 64 0
P A560555B 64 0
P A56E6E6E 64 0
P 0050645A 64 0
P A560555B 64 0
P A56E6E6E 64 0
P 0050645A 64 0
P 00706A72 64 0
P A56E6E6E 64 0
P 0050645A 64 0
P 00706A72 64 0
P A560555B 64 0
P 0050383A 43 0
P 0080686A 70 0
P A5909092 8F 0
P 00FFA0A3 BD 0
P A5C0C0C1 BD 0
P 00A08090 8F 0
P 00707071 70 0
P A5404041 43 0
P 0080686A 70 0
P A5404041 43 0
P 00FFA0A3 BD 0
P A5909092 8F 0
P 00A08090 8F 0
P A5C0C0C1 BD 0
P 0050383A 43 0
P 00707071 70 0
N 0064

/* src.f */
src/denoise_pkg.sv
src/pixel_stream_if.sv
src/rgb_to_luma.sv
src/block_stats_buffer.sv
src/noise_estimator.sv
src/wiener_filter.sv
src/denoise_top.sv
tests/denoise_tb.sv
